//--- src/snoop_arb_pkg.sv
package snoop_arb_pkg;

   // number of snoop sources and the width of a source tag.
   localparam int NUM_SRC = 8;
   localparam int TAG_W   = 3;

   // the tree has no delay stage at 0, a stage on every second level at 1 and
   // a stage on every level at 2.
   localparam int DELAY_CONF = 1;

   localparam int ADDR_W = 32;
   localparam int CNT_W  = 16;

   // byte offsets of the configuration registers.
   localparam logic [3:0] REG_ENABLE  = 4'h0;
   localparam logic [3:0] REG_CNT_SEL = 4'h4;
   localparam logic [3:0] REG_COUNT   = 4'h8;
   localparam logic [3:0] REG_CLEAR   = 4'hC;

   typedef enum logic [1:0] {
      SNP_READ_SHARED   = 2'd0,
      SNP_READ_UNIQUE   = 2'd1,
      SNP_CLEAN_INVALID = 2'd2,
      SNP_MAKE_INVALID  = 2'd3
   } snoop_op_e;

   typedef struct packed {
      snoop_op_e         op;
      logic [ADDR_W-1:0] addr;
   } snoop_req_t;

   // a request as it leaves the arbiter, tagged with its source number.
   typedef struct packed {
      snoop_req_t       req;
      logic [TAG_W-1:0] tag;
   } snoop_fwd_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [3:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

endpackage

//--- src/tree_node.sv
`timescale 1ns/100ps

module tree_node #(
   parameter int TAG_W        = 3,
   parameter bit ENABLE_DELAY = 1'b0
) (
   input  logic             clk_i,
   input  logic             rst_n_i,

   input  logic [TAG_W-1:0] left_tag_i,
   input  logic             left_rdy_i,
   output logic             left_ack_o,

   input  logic [TAG_W-1:0] right_tag_i,
   input  logic             right_rdy_i,
   output logic             right_ack_o,

   output logic [TAG_W-1:0] tag_o,
   output logic             rdy_o,
   input  logic             ack_i
);

   if (ENABLE_DELAY) begin : g_delay
      logic             vld_q;
      logic             sel_q;
      logic [TAG_W-1:0] tag_q;
      logic             avail_l;
      logic             avail_r;
      logic             pick_right;
      logic             load;

      // the side that is draining still shows rdy for the request being
      // acknowledged, so it is not a candidate for the refill.
      assign avail_l    = left_rdy_i & ~(vld_q & ~sel_q);
      assign avail_r    = right_rdy_i & ~(vld_q & sel_q);
      // sel_q also remembers the side served last.
      assign pick_right = (avail_l & avail_r) ? ~sel_q : avail_r;
      assign load       = (avail_l | avail_r) & (~vld_q | ack_i);

      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            vld_q <= 1'b0;
            sel_q <= 1'b0;
         end else if (load) begin
            vld_q <= 1'b1;
            sel_q <= pick_right;
         end else if (ack_i) begin
            vld_q <= 1'b0;
         end
      end

      always_ff @(posedge clk_i) begin
         if (load) begin
            tag_q <= pick_right ? right_tag_i : left_tag_i;
         end
      end

      assign tag_o       = tag_q;
      assign rdy_o       = vld_q;
      // the chosen child keeps its rdy up, so the ack goes straight back.
      assign left_ack_o  = ack_i & vld_q & ~sel_q;
      assign right_ack_o = ack_i & vld_q & sel_q;
   end else begin : g_comb
      logic last_right_q;
      logic locked_q;
      logic lock_sel_q;
      logic pick_right;
      logic sel;

      assign pick_right = (left_rdy_i & right_rdy_i) ? ~last_right_q : right_rdy_i;
      // once the output is pending the choice is frozen until it is taken.
      assign sel        = locked_q ? lock_sel_q : pick_right;

      assign tag_o       = sel ? right_tag_i : left_tag_i;
      assign rdy_o       = sel ? right_rdy_i : left_rdy_i;
      assign left_ack_o  = ack_i & ~sel & left_rdy_i;
      assign right_ack_o = ack_i & sel & right_rdy_i;

      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            last_right_q <= 1'b0;
            locked_q     <= 1'b0;
            lock_sel_q   <= 1'b0;
         end else if (rdy_o && ack_i) begin
            last_right_q <= sel;
            locked_q     <= 1'b0;
         end else if (rdy_o) begin
            locked_q   <= 1'b1;
            lock_sel_q <= sel;
         end
      end
   end

endmodule

//--- src/tag_tree.sv
`timescale 1ns/100ps

module tag_tree #(
   parameter int NUM_LEAF   = 8,
   parameter int TAG_W      = 3,
   parameter int DELAY_CONF = 1
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  logic [NUM_LEAF-1:0] rdy_in_i,
   output logic [NUM_LEAF-1:0] ack_out_o,

   output logic [TAG_W-1:0]    tag_o,
   output logic                rdy_o,
   input  logic                ack_i
);

   localparam int NUM_NODE = 2 * NUM_LEAF - 1;

   // slots 0 to NUM_LEAF-1 are the leaves, node k drives slot NUM_LEAF+k.
   logic [TAG_W-1:0]    tags [NUM_NODE];
   logic [NUM_NODE-1:0] rdys;
   logic [NUM_NODE-1:0] acks;

   for (genvar k = 0; k < NUM_LEAF; k++) begin : g_leaf
      assign tags[k]      = TAG_W'(k);
      assign rdys[k]      = rdy_in_i[k];
      assign ack_out_o[k] = acks[k];
   end

   for (genvar k = 0; k < NUM_LEAF - 1; k++) begin : g_node
      // the root is node NUM_LEAF-2 at depth 0, and DEPTH counts the levels below it.
      localparam int DEPTH = $clog2(NUM_LEAF - k) - 1;
      localparam bit DLY   = (DELAY_CONF == 2) || ((DELAY_CONF == 1) && (DEPTH % 2 == 0));

      tree_node #(
         .TAG_W        (TAG_W),
         .ENABLE_DELAY (DLY)
      ) i_node (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .left_tag_i  (tags[2*k]),
         .left_rdy_i  (rdys[2*k]),
         .left_ack_o  (acks[2*k]),
         .right_tag_i (tags[2*k+1]),
         .right_rdy_i (rdys[2*k+1]),
         .right_ack_o (acks[2*k+1]),
         .tag_o       (tags[NUM_LEAF+k]),
         .rdy_o       (rdys[NUM_LEAF+k]),
         .ack_i       (acks[NUM_LEAF+k])
      );
   end

   assign tag_o              = tags[NUM_NODE-1];
   assign rdy_o              = rdys[NUM_NODE-1];
   assign acks[NUM_NODE-1]   = ack_i;

endmodule

//--- src/snoop_port_mux.sv
`timescale 1ns/100ps

module snoop_port_mux
   import snoop_arb_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   input  snoop_req_t [NUM_SRC-1:0] src_req_i,
   input  logic [NUM_SRC-1:0]       src_rdy_i,
   output logic [NUM_SRC-1:0]       src_ack_o,
   input  logic [NUM_SRC-1:0]       src_en_i,

   output snoop_fwd_t               fwd_o,
   output logic                     fwd_rdy_o,
   input  logic                     fwd_ack_i,

   output logic [NUM_SRC-1:0]       grant_o
);

   logic [NUM_SRC-1:0] offered_q;
   logic [NUM_SRC-1:0] tree_rdy;
   logic [TAG_W-1:0]   root_tag;
   logic               fire;

   // a request already offered to the tree stays eligible after its enable
   // drops, so a node holding it never sees its rdy vanish.
   // only new requests are masked.
   assign tree_rdy = src_rdy_i & (src_en_i | offered_q);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         offered_q <= '0;
      end else begin
         offered_q <= tree_rdy & ~src_ack_o;
      end
   end

   tag_tree #(
      .NUM_LEAF   (NUM_SRC),
      .TAG_W      (TAG_W),
      .DELAY_CONF (DELAY_CONF)
   ) i_tag_tree (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rdy_in_i  (tree_rdy),
      .ack_out_o (src_ack_o),
      .tag_o     (root_tag),
      .rdy_o     (fwd_rdy_o),
      .ack_i     (fwd_ack_i)
   );

   // the winning source holds its payload until acked, so this mux is stable
   // for as long as the root tag is.
   assign fwd_o.req = src_req_i[root_tag];
   assign fwd_o.tag = root_tag;

   assign fire = fwd_rdy_o & fwd_ack_i;

   always_comb begin
      grant_o = '0;
      if (fire) begin
         grant_o = NUM_SRC'(1) << root_tag;
      end
   end

endmodule

//--- src/arb_apb_regs.sv
`timescale 1ns/100ps

module arb_apb_regs
   import snoop_arb_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  apb_req_t           apb_i,
   output apb_rsp_t           apb_o,

   input  logic [NUM_SRC-1:0] grant_i,
   output logic [NUM_SRC-1:0] src_en_o
);

   logic [NUM_SRC-1:0] en_q;
   logic [TAG_W-1:0]   sel_q;
   logic [CNT_W-1:0]   cnt_q [NUM_SRC];
   logic               access;
   logic               bad;
   logic               wr_ok;
   logic [NUM_SRC-1:0] clr;

   // the slave has no wait states, so every access phase completes.
   assign access = apb_i.psel & apb_i.penable;

   // only word offsets are mapped, and COUNT is read only.
   assign bad = (apb_i.paddr[1:0] != 2'b00) |
                (apb_i.pwrite & (apb_i.paddr == REG_COUNT));

   assign wr_ok = access & apb_i.pwrite & ~bad;

   assign clr = (wr_ok && (apb_i.paddr == REG_CLEAR)) ? apb_i.pwdata[NUM_SRC-1:0] : '0;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q  <= '1;
         sel_q <= '0;
      end else if (wr_ok) begin
         case (apb_i.paddr)
            REG_ENABLE: begin
               en_q <= apb_i.pwdata[NUM_SRC-1:0];
            end
            REG_CNT_SEL: begin
               sel_q <= apb_i.pwdata[TAG_W-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   // one saturating counter per source.
   // a clear in the same cycle as a grant wins.
   for (genvar i = 0; i < NUM_SRC; i++) begin : g_cnt
      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            cnt_q[i] <= '0;
         end else if (clr[i]) begin
            cnt_q[i] <= '0;
         end else if (grant_i[i] && (cnt_q[i] != '1)) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end
   end

   always_comb begin
      apb_o         = '0;
      apb_o.pready  = 1'b1;
      apb_o.pslverr = access & bad;
      if (access && !apb_i.pwrite) begin
         case (apb_i.paddr)
            REG_ENABLE: begin
               apb_o.prdata = 32'(en_q);
            end
            REG_CNT_SEL: begin
               apb_o.prdata = 32'(sel_q);
            end
            REG_COUNT: begin
               apb_o.prdata = 32'(cnt_q[sel_q]);
            end
            default: begin
               apb_o.prdata = '0;
            end
         endcase
      end
   end

   assign src_en_o = en_q;

endmodule

//--- src/snoop_arb.sv
`timescale 1ns/100ps

module snoop_arb
   import snoop_arb_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   // snoop sources
   input  snoop_req_t [NUM_SRC-1:0] src_req_i,
   input  logic [NUM_SRC-1:0]       src_rdy_i,
   output logic [NUM_SRC-1:0]       src_ack_o,

   // downstream snoop port
   output snoop_fwd_t               fwd_o,
   output logic                     fwd_rdy_o,
   input  logic                     fwd_ack_i,

   // configuration
   input  apb_req_t                 apb_i,
   output apb_rsp_t                 apb_o
);

   logic [NUM_SRC-1:0] src_en;
   logic [NUM_SRC-1:0] grant;

   // the mux arbitrates among enabled sources and reports each transfer
   // as a grant pulse for the counters.
   snoop_port_mux i_snoop_port_mux (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .src_req_i (src_req_i),
      .src_rdy_i (src_rdy_i),
      .src_ack_o (src_ack_o),
      .src_en_i  (src_en),
      .fwd_o     (fwd_o),
      .fwd_rdy_o (fwd_rdy_o),
      .fwd_ack_i (fwd_ack_i),
      .grant_o   (grant)
   );

   arb_apb_regs i_arb_apb_regs (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .apb_i    (apb_i),
      .apb_o    (apb_o),
      .grant_i  (grant),
      .src_en_o (src_en)
   );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset is released with the other inputs, 10 ns after a rising edge.
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #10;
      rst_n_o = 1'b1;
   end

endmodule

//--- tb/snoop_arb_tb.sv
`timescale 1ns/100ps

module snoop_arb_tb
   import snoop_arb_pkg::*;
();

   typedef enum {ACK_RANDOM, ACK_ON, ACK_STALL} ack_mode_e;

   // cycle budgets of tests 1 to 6.
   localparam int BUDGET_CYC = 120 + 120 + 1000 + 600 + 300 + 60;

   logic                     clk;
   logic                     rst_n;
   snoop_req_t [NUM_SRC-1:0] src_req;
   logic [NUM_SRC-1:0]       src_rdy;
   logic [NUM_SRC-1:0]       src_ack;
   snoop_fwd_t               fwd;
   logic                     fwd_rdy;
   logic                     fwd_ack;
   apb_req_t                 apb_req;
   apb_rsp_t                 apb_rsp;

   logic [NUM_SRC-1:0] src_on = '0;
   logic [NUM_SRC-1:0] dis_chk = '0;
   ack_mode_e          ack_mode = ACK_STALL;
   logic [NUM_SRC-1:0] ack_smp = '0;
   snoop_fwd_t         fwd_now;
   snoop_fwd_t         fwd_prev;
   int                 xfer_cnt = 0;
   int                 ack_cnt [NUM_SRC] = '{default: 0};
   int                 clr_base [NUM_SRC] = '{default: 0};
   int                 err_cnt = 0;
   int                 test_err_base = 0;
   int                 n_ok = 0;
   int                 n_bad = 0;

   tb_clk_gen i_tb_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   snoop_arb i_snoop_arb (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .src_req_i (src_req),
      .src_rdy_i (src_rdy),
      .src_ack_o (src_ack),
      .fwd_o     (fwd),
      .fwd_rdy_o (fwd_rdy),
      .fwd_ack_i (fwd_ack),
      .apb_i     (apb_req),
      .apb_o     (apb_rsp)
   );

   task automatic note_mismatch(input string sig, input logic [63:0] got,
                                input logic [63:0] exp);
      $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", sig, got, exp, $time);
      err_cnt++;
   endtask

   task automatic note_failure(input string msg);
      $display("error at %0t: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic finish_test(input string name);
      if (err_cnt == test_err_base) begin
         n_ok++;
         $display("%s: done, no errors", name);
      end else begin
         n_bad++;
         $display("%s: done, %0d errors", name, err_cnt - test_err_base);
      end
      test_err_base = err_cnt;
   endtask

   // the acknowledge goes to the forwarded source only, in the transfer cycle.
   function automatic logic [NUM_SRC-1:0] exp_ack(input logic rdy, input logic ack,
                                                  input logic [TAG_W-1:0] tag);
      if (rdy && ack) begin
         return NUM_SRC'(1) << tag;
      end
      return '0;
   endfunction

   // unaligned offsets are unmapped and COUNT at 0x8 cannot be written.
   function automatic logic exp_slverr(input logic wr, input logic [3:0] addr);
      return (addr[1:0] != 2'b00) || (wr && (addr == 4'h8));
   endfunction

   // source models hold rdy and payload until their ack, then start anew.
   initial begin : drive_sources
      src_rdy = '0;
      src_req = '0;
      forever begin
         @(posedge clk);
         #10;
         for (int i = 0; i < NUM_SRC; i++) begin
            if (!src_rdy[i] || ack_smp[i]) begin
               src_rdy[i]      = src_on[i];
               src_req[i].op   = snoop_op_e'(2'($urandom_range(0, 3)));
               src_req[i].addr = $urandom;
            end
         end
      end
   end

   initial begin : drive_downstream
      fwd_ack = 1'b0;
      forever begin
         @(posedge clk);
         #10;
         case (ack_mode)
            ACK_RANDOM: fwd_ack = 1'($urandom_range(0, 1));
            ACK_ON:     fwd_ack = 1'b1;
            default:    fwd_ack = 1'b0;
         endcase
      end
   end

   // outputs are sampled in mid cycle, where they are stable.
   always @(negedge clk) begin
      fwd_prev <= fwd_now;
      fwd_now  <= fwd;
      ack_smp  <= src_ack;
      if (rst_n && fwd_rdy && fwd_ack) begin
         xfer_cnt <= xfer_cnt + 1;
      end
      for (int i = 0; i < NUM_SRC; i++) begin
         if (src_ack[i]) begin
            ack_cnt[i] <= ack_cnt[i] + 1;
         end
      end
   end

   a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      src_ack == exp_ack(fwd_rdy, fwd_ack, fwd.tag))
      else note_mismatch("src_ack_o", 64'($sampled(src_ack)),
                         64'(exp_ack($sampled(fwd_rdy), $sampled(fwd_ack), $sampled(fwd.tag))));

   a_payload: assert property (@(posedge clk) disable iff (!rst_n)
      fwd_rdy |-> fwd.req == src_req[fwd.tag])
      else note_mismatch("fwd_o.req", 64'($sampled(fwd.req)), 64'(src_req[$sampled(fwd.tag)]));

   a_src_pending: assert property (@(posedge clk) disable iff (!rst_n)
      fwd_rdy |-> src_rdy[fwd.tag])
      else note_failure("fwd_rdy_o is high for a source without a pending request");

   a_stall_data: assert property (@(posedge clk) disable iff (!rst_n)
      fwd_rdy && !fwd_ack |=> $stable(fwd))
      else note_mismatch("fwd_o", 64'(fwd_now), 64'(fwd_prev));

   a_stall_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      fwd_rdy && !fwd_ack |=> fwd_rdy)
      else note_mismatch("fwd_rdy_o", 64'(0), 64'(1));

   a_disabled: assert property (@(posedge clk) disable iff (!rst_n)
      (src_ack & dis_chk) == '0)
      else note_mismatch("src_ack_o", 64'($sampled(src_ack)), 64'($sampled(src_ack & ~dis_chk)));

   a_pready: assert property (@(posedge clk) disable iff (!rst_n) apb_rsp.pready)
      else note_mismatch("pready", 64'(0), 64'(1));

   a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
      apb_req.psel && apb_req.penable |->
         apb_rsp.pslverr == exp_slverr(apb_req.pwrite, apb_req.paddr))
      else note_mismatch("pslverr", 64'($sampled(apb_rsp.pslverr)),
                         64'(exp_slverr($sampled(apb_req.pwrite), $sampled(apb_req.paddr))));

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_transfers(input int n, input int max_cyc);
      int start;
      int cyc;
      start = xfer_cnt;
      cyc   = 0;
      while ((xfer_cnt - start < n) && (cyc < max_cyc)) begin
         @(negedge clk);
         cyc++;
      end
      if (xfer_cnt - start < n) begin
         note_failure($sformatf("only %0d of %0d transfers within %0d cycles",
                                xfer_cnt - start, n, max_cyc));
      end
   endtask

   // one APB transfer with a setup and an access phase.
   task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(posedge clk);
      #10;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #10;
      apb_req.penable = 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      #10;
      apb_req = '0;
      @(negedge clk);
   endtask

   task automatic check_count(input int idx);
      logic [31:0] rdata;
      logic        err;
      int          exp;
      exp = ack_cnt[idx] - clr_base[idx];
      apb_access(1'b1, 4'h4, 32'(idx), rdata, err);
      apb_access(1'b0, 4'h8, 32'h0, rdata, err);
      assert (rdata == 32'(exp))
         else note_mismatch($sformatf("COUNT[%0d]", idx), 64'(rdata), 64'(exp));
   endtask

   task automatic expect_slverr(input logic wr, input logic [3:0] addr, input logic exp);
      logic [31:0] rdata;
      logic        err;
      apb_access(wr, addr, 32'hFF, rdata, err);
      assert (err == exp)
         else note_mismatch($sformatf("pslverr at 0x%0h", addr), 64'(err), 64'(exp));
   endtask

   initial begin : run_tests
      logic [31:0]        rdata;
      logic               err;
      logic [NUM_SRC-1:0] pending;
      int                 base [NUM_SRC];
      int                 lo;
      int                 hi;
      int                 cyc;
      void'($urandom(32'hff56));
      apb_req = '0;
      wait (rst_n);
      @(negedge clk);

      assert (fwd_rdy == 1'b0) else note_mismatch("fwd_rdy_o", 64'(fwd_rdy), 64'(0));
      assert (src_ack == '0) else note_mismatch("src_ack_o", 64'(src_ack), 64'(0));
      for (int i = 0; i < NUM_SRC; i++) begin
         check_count(i);
      end
      src_on   = 8'h20;
      ack_mode = ACK_ON;
      wait_transfers(4, 40);
      assert (ack_cnt[5] == 4) else note_mismatch("acks of source 5", 64'(ack_cnt[5]), 64'(4));
      finish_test("test 1 reset and lone source");

      src_on   = '1;
      ack_mode = ACK_RANDOM;
      wait_cycles(20);
      ack_mode = ACK_STALL;
      wait_cycles(20);
      ack_mode = ACK_RANDOM;
      wait_cycles(20);
      ack_mode = ACK_STALL;
      wait_cycles(10);
      ack_mode = ACK_RANDOM;
      finish_test("test 2 back-pressure");

      base = ack_cnt;
      wait_transfers(400, 1000);
      lo = ack_cnt[0] - base[0];
      hi = lo;
      for (int i = 1; i < NUM_SRC; i++) begin
         lo = (ack_cnt[i] - base[i] < lo) ? ack_cnt[i] - base[i] : lo;
         hi = (ack_cnt[i] - base[i] > hi) ? ack_cnt[i] - base[i] : hi;
      end
      assert (lo > 0) else note_failure("a requesting source was never granted");
      assert (hi - lo <= 2)
         else note_failure($sformatf("grant counts spread from %0d to %0d", lo, hi));
      finish_test("test 3 fairness");

      // with the downstream stalled every source holds an accepted request.
      ack_mode = ACK_STALL;
      wait_cycles(4);
      apb_access(1'b1, 4'h0, 32'hC3, rdata, err);
      ack_mode = ACK_ON;
      pending  = 8'h3C;
      cyc      = 0;
      while ((pending != '0) && (cyc < 100)) begin
         @(negedge clk);
         pending = pending & ~src_ack;
         cyc++;
      end
      assert (pending == '0) else note_failure("accepted requests of disabled sources never drained");
      // the last of those acks completes only at the coming rising edge.
      wait_cycles(1);
      dis_chk  = 8'h3C;
      ack_mode = ACK_RANDOM;
      base     = ack_cnt;
      wait_transfers(100, 400);
      for (int i = 0; i < NUM_SRC; i++) begin
         assert (dis_chk[i] || (ack_cnt[i] > base[i]))
            else note_failure($sformatf("enabled source %0d was not acknowledged", i));
      end
      dis_chk = '0;
      apb_access(1'b1, 4'h0, 32'hFF, rdata, err);
      finish_test("test 4 enable mask");

      // a counter moves one cycle after its grant, so let the last one settle.
      ack_mode = ACK_STALL;
      wait_cycles(3);
      for (int i = 0; i < NUM_SRC; i++) begin
         check_count(i);
      end
      apb_access(1'b1, 4'hC, 32'hA5, rdata, err);
      for (int i = 0; i < NUM_SRC; i++) begin
         if (i inside {0, 2, 5, 7}) begin
            clr_base[i] = ack_cnt[i];
         end
      end
      for (int i = 0; i < NUM_SRC; i++) begin
         check_count(i);
      end
      ack_mode = ACK_RANDOM;
      finish_test("test 5 grant counters");

      expect_slverr(1'b1, 4'h8, 1'b1);
      expect_slverr(1'b1, 4'h6, 1'b1);
      expect_slverr(1'b1, 4'h1, 1'b1);
      expect_slverr(1'b1, 4'h0, 1'b0);
      expect_slverr(1'b0, 4'h8, 1'b0);
      expect_slverr(1'b0, 4'h4, 1'b0);
      finish_test("test 6 apb errors");

      $display("summary: %0d tests clean, %0d tests with errors, %0d errors in all",
               n_ok, n_bad, err_cnt);
      if ((err_cnt == 0) && (n_bad == 0)) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      // each budget cycle is one 100 ns clock, and half again is margin.
      #(BUDGET_CYC * 150);
      $display("watchdog expired after %0d ns before the tests finished", BUDGET_CYC * 150);
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- project.f
src/snoop_arb_pkg.sv
src/tree_node.sv
src/tag_tree.sv
src/snoop_port_mux.sv
src/arb_apb_regs.sv
src/snoop_arb.sv
tb/tb_clk_gen.sv
tb/snoop_arb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the snoop arbiter testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module snoop_arb_tb -o snoop_arb_sim \
   && ./obj_dir/snoop_arb_sim | tee /dev/stderr | grep -q "TEST PASSED" \
   && echo "simulation ok" \
   || { echo "simulation not ok"; exit 1; }
